/* Makefile */
BIN  := obj_dir/Vsystem_io_tb
SRCS := $(wildcard include/*.svh logic/*.sv verification/*.sv)

.PHONY: run clean

run: $(BIN)
	./$(BIN) 2>&1 | tee sim.log
	grep -q -F '*** PASSED ***' sim.log

$(BIN): src.f $(SRCS)
	verilator --binary --timing --assert -j 0 --Mdir obj_dir \
		--top-module system_io_tb -f src.f

clean:
	rm -rf obj_dir sim.log

/* include/io_hub_macros.svh */
`ifndef IO_HUB_MACROS_SVH
`define IO_HUB_MACROS_SVH

// ========================================
// widths
// ========================================
`define IO_ADDR_W 16
`define IO_DATA_W 32
`define IO_LEN_W  3
`define IO_BYTE_W 8

// ========================================
// port map
// ========================================
// _MW is the count of low address bits ignored by the match.
`define PORT_FLOPPY_BASE   16'h03F0
`define PORT_FLOPPY_MW     3
`define PORT_DMA_MST_BASE  16'h00C0
`define PORT_DMA_MST_MW    5
`define PORT_DMA_SLV_BASE  16'h0000
`define PORT_DMA_SLV_MW    4
`define PORT_DMA_PAGE_BASE 16'h0080
`define PORT_DMA_PAGE_MW   4
`define PORT_PIC_MST_BASE  16'h0020
`define PORT_PIC_SLV_BASE  16'h00A0
`define PORT_PIC_MW        1
`define PORT_PIT_BASE      16'h0040
`define PORT_PIT_MW        2
`define PORT_PIT_SPKR      16'h0061
`define PORT_PS2_IO_BASE   16'h0060
`define PORT_PS2_IO_MW     3
`define PORT_PS2_CTL_BASE  16'h0090
`define PORT_PS2_CTL_MW    4
`define PORT_RTC_BASE      16'h0070
`define PORT_RTC_MW        1
`define PORT_SB_BASE       16'h0220
`define PORT_SB_MW         4
`define PORT_FM_BASE       16'h0388
`define PORT_FM_MW         2
`define PORT_UART_BASE     16'h03F8
`define PORT_UART_MW       3
`define PORT_MPU_BASE      16'h0330
`define PORT_MPU_MW        1
`define PORT_VGA_B_BASE    16'h03B0
`define PORT_VGA_C_BASE    16'h03C0
`define PORT_VGA_D_BASE    16'h03D0
`define PORT_VGA_MW        4
`define PORT_JOY_BASE      16'h0201
`define PORT_JOY_MW        0
`define PORT_HDD0_BASE     16'h01F0
`define PORT_HDD0_ALT      16'h03F6
`define PORT_HDD1_BASE     16'h0170
`define PORT_HDD1_ALT      16'h0376
`define PORT_HDD_MW        3
`define PORT_SYSCFG        16'h8888

// ========================================
// device groups, bit positions in the selects
// ========================================
`define DEV_COUNT  12
`define DEV_FLOPPY 0
`define DEV_DMA    1
`define DEV_PIC    2
`define DEV_PIT    3
`define DEV_PS2    4
`define DEV_RTC    5
`define DEV_SOUND  6
`define DEV_UART   7
`define DEV_VGA    8
`define DEV_JOY    9
`define DEV_HDD0   10
`define DEV_HDD1   11

`define SYSCFG_KEY   8'hA1
`define SYSCFG_RESET 8'hA2
`define IO_IDLE_BYTE 8'hFF

`endif

/* logic/io_bus_if.sv */
`timescale 1ns/1ps

interface io_bus_if;
	import io_hub_pkg::*;

	// sequencer side.
	io_addr_t address;
	logic     read;
	logic     write;
	io_len_t  datasize;
	io_word_t writedata;

	// decoder side.
	io_word_t readdata;
	logic     io32;       // whole access in one cycle.
	dev_sel_t sel;

	modport sequencer (
		output address, read, write, datasize, writedata,
		input  readdata, io32
	);

	modport decoder (
		input  address, read, write,
		output readdata, io32, sel
	);

	// observer only.
	modport cfg (
		input address, read, write, datasize, writedata, sel
	);

endinterface

/* logic/io_cycle_sequencer.sv */
`timescale 1ns/1ps
`include "io_hub_macros.svh"

module io_cycle_sequencer (
	input  logic                 clk_sys,
	input  logic                 reset,

	input  logic                 io_read_do,
	input  io_hub_pkg::io_addr_t io_read_address,
	input  io_hub_pkg::io_len_t  io_read_length,
	output io_hub_pkg::io_word_t io_read_data,
	output logic                 io_read_done,

	input  logic                 io_write_do,
	input  io_hub_pkg::io_addr_t io_write_address,
	input  io_hub_pkg::io_len_t  io_write_length,
	input  io_hub_pkg::io_word_t io_write_data,
	output logic                 io_write_done,

	io_bus_if.sequencer          bus
);
	import io_hub_pkg::*;

	seq_state_t state;
	seq_state_t state_next;

	logic       op_write;
	io_len_t    op_len;
	io_addr_t   cur_addr;
	io_word_t   wdata;
	io_word_t   rdata;
	logic [1:0] byte_idx;
	logic       last_byte;

	assign last_byte = ({1'b0, byte_idx} + io_len_t'(1)) == op_len;

	// ========================================
	// state machine
	// ========================================
	always_comb begin
		state_next = state;
		case (state)
			SEQ_IDLE: begin
				if (io_write_do || io_read_do)
					state_next = SEQ_SETUP;
			end
			SEQ_SETUP: begin
				state_next = SEQ_STROBE;   // decoder registers selects here.
			end
			SEQ_STROBE: begin
				if (bus.io32 || last_byte)
					state_next = SEQ_FINISH;
				else
					state_next = SEQ_SETUP;
			end
			SEQ_FINISH: begin
				state_next = SEQ_IDLE;
			end
			default: begin
				state_next = SEQ_IDLE;
			end
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (reset)
			state <= SEQ_IDLE;
		else
			state <= state_next;
	end

	// ========================================
	// access fields and byte assembly
	// ========================================
	always_ff @(posedge clk_sys) begin
		if (state == SEQ_IDLE) begin
			// write wins when both are pending.
			op_write <= io_write_do;
			op_len   <= io_write_do ? io_write_length : io_read_length;
			cur_addr <= io_write_do ? io_write_address : io_read_address;
			wdata    <= io_write_data;
			rdata    <= '0;
			byte_idx <= '0;
		end
		else if (state == SEQ_STROBE) begin
			if (!op_write) begin
				if (bus.io32)
					rdata <= bus.readdata;
				else
					rdata[{byte_idx, 3'b000} +: `IO_BYTE_W] <= bus.readdata[`IO_BYTE_W-1:0];
			end
			if (!bus.io32) begin
				cur_addr <= cur_addr + io_addr_t'(1);   // next byte port.
				wdata    <= wdata >> `IO_BYTE_W;
				byte_idx <= byte_idx + 2'd1;
			end
		end
	end

	assign bus.address   = cur_addr;
	assign bus.read      = (state == SEQ_STROBE) && !op_write;
	assign bus.write     = (state == SEQ_STROBE) && op_write;
	assign bus.datasize  = bus.io32 ? op_len : io_len_t'(1);
	assign bus.writedata = wdata;

	assign io_read_data  = rdata;
	assign io_read_done  = (state == SEQ_FINISH) && !op_write;
	assign io_write_done = (state == SEQ_FINISH) && op_write;

	// ========================================
	// checks
	// ========================================
	a_done_pulse: assert property (@(posedge clk_sys) disable iff (reset)
		(io_read_done || io_write_done) |=> !(io_read_done || io_write_done));

	a_strobe_excl: assert property (@(posedge clk_sys) disable iff (reset)
		!(bus.read && bus.write));

endmodule

/* logic/io_hub_pkg.sv */
`include "io_hub_macros.svh"

package io_hub_pkg;

	// ========================================
	// bus vectors
	// ========================================
	typedef logic [`IO_ADDR_W-1:0] io_addr_t;
	typedef logic [`IO_DATA_W-1:0] io_word_t;
	typedef logic [`IO_BYTE_W-1:0] io_byte_t;
	typedef logic [`IO_LEN_W-1:0]  io_len_t;   // bytes per access.

	// one chip select per device group.
	typedef logic [`DEV_COUNT-1:0] dev_sel_t;

	// ========================================
	// sequencer
	// ========================================
	typedef enum logic [1:0] {
		SEQ_IDLE,
		SEQ_SETUP,
		SEQ_STROBE,
		SEQ_FINISH
	} seq_state_t;

endpackage

/* logic/port_decoder.sv */
`timescale 1ns/1ps
`include "io_hub_macros.svh"

module port_decoder (
	input  logic                                   clk_sys,
	input  logic                                   reset,
	input  io_hub_pkg::io_byte_t [`DEV_COUNT-1:0] dev_readdata,
	input  io_hub_pkg::io_word_t                   hdd0_readdata,
	input  io_hub_pkg::io_word_t                   hdd1_readdata,
	output io_hub_pkg::dev_sel_t                   dev_cs,
	io_bus_if.decoder                              bus
);
	import io_hub_pkg::*;

	dev_sel_t raw_hit;
	dev_sel_t sel_next;
	logic     io32_next;
	io_byte_t dev_byte;

	function automatic logic port_hit(input io_addr_t addr, input io_addr_t base, input int mw);
		return (addr >> mw) == (base >> mw);
	endfunction

	// one group per port; lowest index first, disks above all.
	function automatic dev_sel_t pick_one(input dev_sel_t hits);
		dev_sel_t pick;
		pick = '0;
		for (int i = `DEV_COUNT - 1; i >= 0; i--) begin
			if (hits[i])
				pick = dev_sel_t'(1) << i;
		end
		if (hits[`DEV_HDD1])
			pick = dev_sel_t'(1) << `DEV_HDD1;
		if (hits[`DEV_HDD0])
			pick = dev_sel_t'(1) << `DEV_HDD0;   // 0x3F6 overlaps the floppy.
		return pick;
	endfunction

	// ========================================
	// address decode
	// ========================================
	always_comb begin
		raw_hit = '0;
		raw_hit[`DEV_FLOPPY] = port_hit(bus.address, `PORT_FLOPPY_BASE, `PORT_FLOPPY_MW);
		raw_hit[`DEV_DMA]    = port_hit(bus.address, `PORT_DMA_MST_BASE, `PORT_DMA_MST_MW) ||
			port_hit(bus.address, `PORT_DMA_SLV_BASE, `PORT_DMA_SLV_MW) ||
			port_hit(bus.address, `PORT_DMA_PAGE_BASE, `PORT_DMA_PAGE_MW);
		raw_hit[`DEV_PIC]    = port_hit(bus.address, `PORT_PIC_MST_BASE, `PORT_PIC_MW) ||
			port_hit(bus.address, `PORT_PIC_SLV_BASE, `PORT_PIC_MW);
		raw_hit[`DEV_PIT]    = port_hit(bus.address, `PORT_PIT_BASE, `PORT_PIT_MW) ||
			(bus.address == `PORT_PIT_SPKR);
		raw_hit[`DEV_PS2]    = port_hit(bus.address, `PORT_PS2_IO_BASE, `PORT_PS2_IO_MW) ||
			port_hit(bus.address, `PORT_PS2_CTL_BASE, `PORT_PS2_CTL_MW);
		raw_hit[`DEV_RTC]    = port_hit(bus.address, `PORT_RTC_BASE, `PORT_RTC_MW);
		raw_hit[`DEV_SOUND]  = port_hit(bus.address, `PORT_SB_BASE, `PORT_SB_MW) ||
			port_hit(bus.address, `PORT_FM_BASE, `PORT_FM_MW);
		raw_hit[`DEV_UART]   = port_hit(bus.address, `PORT_UART_BASE, `PORT_UART_MW) ||
			port_hit(bus.address, `PORT_MPU_BASE, `PORT_MPU_MW);
		raw_hit[`DEV_VGA]    = port_hit(bus.address, `PORT_VGA_B_BASE, `PORT_VGA_MW) ||
			port_hit(bus.address, `PORT_VGA_C_BASE, `PORT_VGA_MW) ||
			port_hit(bus.address, `PORT_VGA_D_BASE, `PORT_VGA_MW);
		raw_hit[`DEV_JOY]    = port_hit(bus.address, `PORT_JOY_BASE, `PORT_JOY_MW);
		raw_hit[`DEV_HDD0]   = port_hit(bus.address, `PORT_HDD0_BASE, `PORT_HDD_MW) ||
			(bus.address == `PORT_HDD0_ALT);
		raw_hit[`DEV_HDD1]   = port_hit(bus.address, `PORT_HDD1_BASE, `PORT_HDD_MW) ||
			(bus.address == `PORT_HDD1_ALT);
	end

	assign sel_next  = pick_one(raw_hit);
	// disk data ports and the config port move whole words.
	assign io32_next = ((sel_next[`DEV_HDD0] | sel_next[`DEV_HDD1]) & ~bus.address[9]) |
		(bus.address == `PORT_SYSCFG);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			bus.sel  <= '0;
			bus.io32 <= 1'b0;
		end
		else begin
			bus.sel  <= sel_next;
			bus.io32 <= io32_next;
		end
	end

	assign dev_cs = bus.sel & {`DEV_COUNT{bus.read | bus.write}};

	// ========================================
	// read data
	// ========================================
	always_comb begin
		dev_byte = `IO_IDLE_BYTE;
		for (int i = 0; i < `DEV_COUNT; i++) begin
			if (bus.sel[i])
				dev_byte = dev_readdata[i];
		end
	end

	assign bus.readdata = bus.sel[`DEV_HDD0] ? hdd0_readdata :
		bus.sel[`DEV_HDD1] ? hdd1_readdata :
		{(`IO_DATA_W / `IO_BYTE_W){dev_byte}};   // byte in every lane.

	a_sel_onehot: assert property (@(posedge clk_sys) disable iff (reset)
		$onehot0(bus.sel));

endmodule

/* logic/syscfg_port.sv */
`timescale 1ns/1ps
`include "io_hub_macros.svh"

module syscfg_port (
	input  logic                 clk_sys,
	input  logic                 reset,
	output io_hub_pkg::io_byte_t syscfg,
	io_bus_if.cfg                bus
);
	import io_hub_pkg::*;

	logic first_armed;   // no disk or floppy access seen yet.
	logic disk_strobe;
	logic key_write;

	assign disk_strobe = (bus.read | bus.write) &
		(bus.sel[`DEV_HDD0] | bus.sel[`DEV_HDD1] | bus.sel[`DEV_FLOPPY]);

	// 16-bit write, key in the high byte.
	assign key_write = bus.write && (bus.address == `PORT_SYSCFG) &&
		(bus.datasize == io_len_t'(2)) &&
		(bus.writedata[15:8] == `SYSCFG_KEY);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			syscfg      <= `SYSCFG_RESET;
			first_armed <= 1'b1;
		end
		else if (disk_strobe && first_armed) begin
			syscfg      <= '0;   // boot defaults dropped once.
			first_armed <= 1'b0;
		end
		else if (key_write) begin
			syscfg <= bus.writedata[`IO_BYTE_W-1:0];
		end
	end

endmodule

/* logic/system_io_hub.sv */
`timescale 1ns/1ps
`include "io_hub_macros.svh"

module system_io_hub (
	input  logic                                   clk_sys,
	input  logic                                   reset,

	// ========================================
	// cpu side
	// ========================================
	input  logic                                   io_read_do,
	input  io_hub_pkg::io_addr_t                   io_read_address,
	input  io_hub_pkg::io_len_t                    io_read_length,
	output io_hub_pkg::io_word_t                   io_read_data,
	output logic                                   io_read_done,

	input  logic                                   io_write_do,
	input  io_hub_pkg::io_addr_t                   io_write_address,
	input  io_hub_pkg::io_len_t                    io_write_length,
	input  io_hub_pkg::io_word_t                   io_write_data,
	output logic                                   io_write_done,

	// ========================================
	// device side
	// ========================================
	output io_hub_pkg::dev_sel_t                   dev_cs,
	output io_hub_pkg::io_addr_t                   dev_address,
	output logic                                   dev_read,
	output logic                                   dev_write,
	output io_hub_pkg::io_word_t                   dev_writedata,
	input  io_hub_pkg::io_byte_t [`DEV_COUNT-1:0] dev_readdata,
	input  io_hub_pkg::io_word_t                   hdd0_readdata,
	input  io_hub_pkg::io_word_t                   hdd1_readdata,

	output io_hub_pkg::io_byte_t                   syscfg
);

	io_bus_if bus ();

	io_cycle_sequencer seq0 (
		.clk_sys          (clk_sys),
		.reset            (reset),
		.io_read_do       (io_read_do),
		.io_read_address  (io_read_address),
		.io_read_length   (io_read_length),
		.io_read_data     (io_read_data),
		.io_read_done     (io_read_done),
		.io_write_do      (io_write_do),
		.io_write_address (io_write_address),
		.io_write_length  (io_write_length),
		.io_write_data    (io_write_data),
		.io_write_done    (io_write_done),
		.bus              (bus.sequencer)
	);

	port_decoder dec0 (
		.clk_sys          (clk_sys),
		.reset            (reset),
		.dev_readdata     (dev_readdata),
		.hdd0_readdata    (hdd0_readdata),
		.hdd1_readdata    (hdd1_readdata),
		.dev_cs           (dev_cs),
		.bus              (bus.decoder)
	);

	syscfg_port cfg0 (
		.clk_sys          (clk_sys),
		.reset            (reset),
		.syscfg           (syscfg),
		.bus              (bus.cfg)
	);

	// devices see the internal bus directly.
	assign dev_address   = bus.address;
	assign dev_read      = bus.read;
	assign dev_write     = bus.write;
	assign dev_writedata = bus.writedata;

endmodule

/* src.f */
+incdir+include
logic/io_hub_pkg.sv
logic/io_bus_if.sv
logic/io_cycle_sequencer.sv
logic/port_decoder.sv
logic/syscfg_port.sv
logic/system_io_hub.sv
verification/io_device_model.sv
verification/system_io_tb.sv

/* verification/io_device_model.sv */
`timescale 1ns/1ps
`include "io_hub_macros.svh"

module io_device_model (
	input  logic                                   clk_sys,
	input  io_hub_pkg::dev_sel_t                   dev_cs,
	input  io_hub_pkg::io_addr_t                   dev_address,
	input  logic                                   dev_read,
	input  logic                                   dev_write,
	input  io_hub_pkg::io_word_t                   dev_writedata,
	output io_hub_pkg::io_byte_t [`DEV_COUNT-1:0] dev_readdata,
	output io_hub_pkg::io_word_t                   hdd0_readdata,
	output io_hub_pkg::io_word_t                   hdd1_readdata,
	output io_hub_pkg::dev_sel_t                   last_write_cs,
	output io_hub_pkg::io_addr_t                   last_write_addr,
	output int                                     strobe_count
);
	import io_hub_pkg::*;

	localparam io_word_t HDD0_WORD = 32'h1F0D_15C0;
	localparam io_word_t HDD1_WORD = 32'h170D_15C1;

	io_byte_t mem [`DEV_COUNT][256];   // one byte space per group.

	initial begin
		for (int g = 0; g < `DEV_COUNT; g++) begin
			for (int a = 0; a < 256; a++)
				mem[g][a] = 8'(a * 7) ^ 8'(g << 4) ^ 8'h3C;
		end
		last_write_cs   = '0;
		last_write_addr = '0;
		strobe_count    = 0;
	end

	// devices answer in the strobe cycle.
	always_comb begin
		for (int g = 0; g < `DEV_COUNT; g++)
			dev_readdata[g] = mem[g][dev_address[7:0]];
	end

	assign hdd0_readdata = HDD0_WORD;
	assign hdd1_readdata = HDD1_WORD;

	always @(posedge clk_sys) begin
		if (dev_read || dev_write)
			strobe_count = strobe_count + 1;
		if (dev_write) begin
			last_write_cs   = dev_cs;   // write log.
			last_write_addr = dev_address;
			for (int g = 0; g < `DEV_COUNT; g++) begin
				if (dev_cs[g])
					mem[g][dev_address[7:0]] = dev_writedata[7:0];
			end
		end
	end

endmodule

/* verification/system_io_tb.sv */
`timescale 1ns/1ps
`include "io_hub_macros.svh"

module system_io_tb;
	import io_hub_pkg::*;

	localparam int CLK_PERIOD        = 4;
	localparam int DIRECTED_ACCESSES = 33;
	localparam int RANDOM_ACCESSES   = 200;
	localparam int WATCHDOG_NS       = (DIRECTED_ACCESSES + RANDOM_ACCESSES + 4) * 40 * CLK_PERIOD;

	logic     clk_sys = 1'b0;
	logic     reset;
	logic     io_read_do;
	io_addr_t io_read_address;
	io_len_t  io_read_length;
	io_word_t io_read_data;
	logic     io_read_done;
	logic     io_write_do;
	io_addr_t io_write_address;
	io_len_t  io_write_length;
	io_word_t io_write_data;
	logic     io_write_done;
	dev_sel_t dev_cs;
	io_addr_t dev_address;
	logic     dev_read;
	logic     dev_write;
	io_word_t dev_writedata;
	io_byte_t [`DEV_COUNT-1:0] dev_readdata;
	io_word_t hdd0_readdata;
	io_word_t hdd1_readdata;
	io_byte_t syscfg;
	dev_sel_t last_write_cs;
	io_addr_t last_write_addr;
	int       strobe_count;

	io_byte_t shadow [`DEV_COUNT][256];
	io_word_t exp_rdata;
	io_word_t got_rdata;
	io_byte_t exp_cfg;
	logic     cfg_armed;

	io_addr_t group_base [`DEV_COUNT] = '{`PORT_FLOPPY_BASE, `PORT_DMA_MST_BASE,
		`PORT_PIC_MST_BASE, `PORT_PIT_BASE, `PORT_PS2_IO_BASE, `PORT_RTC_BASE, `PORT_SB_BASE,
		`PORT_UART_BASE, `PORT_VGA_C_BASE, `PORT_JOY_BASE, `PORT_HDD0_BASE, `PORT_HDD1_BASE};
	io_addr_t rand_port [26] = '{16'h0000, 16'h0020, 16'h0040, 16'h0060, 16'h0070, 16'h0080,
		16'h00A0, 16'h00C0, 16'h0220, 16'h0388, 16'h03B0, 16'h03C0, 16'h03D4, 16'h03F8,
		16'h0330, 16'h0201, 16'h03F2, 16'h03F6, 16'h0376, 16'h01F0, 16'h0170, 16'h0300,
		16'h0500, 16'h1234, 16'h8888, 16'h0090};

	system_io_hub dut0 (.*);

	io_device_model model0 (.*);

	always #(CLK_PERIOD / 2) clk_sys = ~clk_sys;

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
			$display("*** FAILED ***");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	// ========================================
	// reference model
	// ========================================
	function automatic int group_of(input io_addr_t a);
		if (a inside {[16'h01F0:16'h01F7], 16'h03F6}) return `DEV_HDD0;   // ahead of floppy.
		if (a inside {[16'h0170:16'h0177], 16'h0376}) return `DEV_HDD1;
		if (a inside {[16'h03F0:16'h03F7]}) return `DEV_FLOPPY;
		if (a inside {[16'h0000:16'h000F], [16'h0080:16'h008F], [16'h00C0:16'h00DF]})
			return `DEV_DMA;
		if (a inside {[16'h0020:16'h0021], [16'h00A0:16'h00A1]}) return `DEV_PIC;
		if (a inside {[16'h0040:16'h0043], 16'h0061}) return `DEV_PIT;
		if (a inside {[16'h0060:16'h0067], [16'h0090:16'h009F]}) return `DEV_PS2;
		if (a inside {[16'h0070:16'h0071]}) return `DEV_RTC;
		if (a inside {[16'h0220:16'h022F], [16'h0388:16'h038B]}) return `DEV_SOUND;
		if (a inside {[16'h03F8:16'h03FF], [16'h0330:16'h0331]}) return `DEV_UART;
		if (a inside {[16'h03B0:16'h03DF]}) return `DEV_VGA;
		if (a == 16'h0201) return `DEV_JOY;
		return -1;
	endfunction

	function automatic logic word_port(input io_addr_t a);
		int g;
		g = group_of(a);
		return ((g == `DEV_HDD0 || g == `DEV_HDD1) && !a[9]) || a == 16'h8888;
	endfunction

	function automatic io_byte_t port_byte(input io_addr_t a);
		int g;
		g = group_of(a);
		if (g < 0)
			return 8'hFF;
		if (g == `DEV_HDD0)
			return hdd0_readdata[7:0];
		if (g == `DEV_HDD1)
			return hdd1_readdata[7:0];
		return shadow[g][a[7:0]];
	endfunction

	function automatic io_word_t expected_read(input io_addr_t a, input io_len_t len);
		io_word_t r;
		int g;
		r = '0;
		g = group_of(a);
		if (word_port(a))
			return g == `DEV_HDD0 ? hdd0_readdata : g == `DEV_HDD1 ? hdd1_readdata : 32'hFFFF_FFFF;
		for (int k = 0; k < int'(len); k++)
			r[8*k +: 8] = port_byte(a + 16'(k));   // byte k in lane k.
		return r;
	endfunction

	// shadow memory and syscfg, one step per bus cycle.
	task automatic apply_access(input bit wr, input io_addr_t a, input io_len_t len,
		input io_word_t d);
		int cycles;
		int g;
		io_addr_t p;
		cycles = word_port(a) ? 1 : int'(len);
		for (int k = 0; k < cycles; k++) begin
			p = a + 16'(k);
			g = group_of(p);
			if (cfg_armed && (g == `DEV_FLOPPY || g == `DEV_HDD0 || g == `DEV_HDD1)) begin
				exp_cfg   = 8'h00;
				cfg_armed = 1'b0;
			end
			else if (wr && p == 16'h8888 && len == 3'd2 && d[15:8] == 8'hA1)
				exp_cfg = d[7:0];
			if (wr && g >= 0)
				shadow[g][p[7:0]] = d[8*k +: 8];
		end
	endtask

	task automatic run_access(input bit wr, input io_addr_t a, input io_len_t len,
		input io_word_t d);
		if (!wr)
			exp_rdata = expected_read(a, len);
		apply_access(wr, a, len, d);
		io_write_do      = wr;
		io_read_do       = !wr;
		io_write_address = a;
		io_read_address  = a;
		io_write_length  = len;
		io_read_length   = len;
		io_write_data    = d;
		@(negedge clk_sys);
		while (!(io_read_done || io_write_done))
			@(negedge clk_sys);
		got_rdata   = io_read_data;
		io_write_do = 1'b0;
		io_read_do  = 1'b0;
		@(negedge clk_sys);
	endtask

	// ========================================
	// compare and watchdog
	// ========================================
	always @(negedge clk_sys) begin
		if (io_read_done)
			check_value("io_read_data", io_read_data, exp_rdata);
		if (io_read_done || io_write_done)
			check_value("syscfg", {24'h0, syscfg}, {24'h0, exp_cfg});
	end

	initial begin
		#(WATCHDOG_NS);
		$display("timeout: the DUT gave no done within %0d ns", WATCHDOG_NS);
		$display("*** FAILED ***");
		$fatal(1, "watchdog expired");
	end

	// ========================================
	// stimulus
	// ========================================
	initial begin
		int s0;
		int pick;
		io_word_t d;
		void'($urandom(32'h65e2_53f2));
		reset = 1'b1;
		{io_read_do, io_write_do} = 2'b00;
		{io_read_address, io_write_address} = '0;
		{io_read_length, io_write_length} = '0;
		io_write_data = '0;
		exp_rdata = '0;
		exp_cfg   = 8'hA2;
		cfg_armed = 1'b1;
		repeat (4) @(negedge clk_sys);
		reset = 1'b0;
		for (int g = 0; g < `DEV_COUNT; g++) begin
			for (int a = 0; a < 256; a++)
				shadow[g][a] = model0.mem[g][a];
		end
		check_value("syscfg", {24'h0, syscfg}, 32'h0000_00A2);
		check_value("io_done", {30'h0, io_read_done, io_write_done}, 32'h0);

		run_access(1'b1, 16'h8888, 3'd2, 32'h0000_A15C);
		run_access(1'b1, 16'h8888, 3'd2, 32'h0000_7733);   // wrong key.

		for (int g = 0; g < `DEV_COUNT; g++) begin
			d = $urandom;
			run_access(1'b1, group_base[g], 3'd1, d);
			check_value("dev_cs", 32'(last_write_cs), 32'(1) << g);
			check_value("dev_address", 32'(last_write_addr), 32'(group_base[g]));
			run_access(1'b0, group_base[g], 3'd1, 32'h0);
			if (g != `DEV_HDD0 && g != `DEV_HDD1)
				check_value("readback", {24'h0, got_rdata[7:0]}, {24'h0, d[7:0]});
		end
		check_value("syscfg", {24'h0, syscfg}, 32'h0);
		run_access(1'b1, 16'h8888, 3'd2, 32'h0000_A13B);
		run_access(1'b1, 16'h8888, 3'd2, 32'h0000_5533);

		run_access(1'b0, 16'h0300, 3'd4, 32'h0);
		check_value("unmapped", got_rdata, 32'hFFFF_FFFF);
		run_access(1'b0, 16'h03C0, 3'd2, 32'h0);
		s0 = strobe_count;
		run_access(1'b0, 16'h03C4, 3'd4, 32'h0);
		check_value("byte_strobes", 32'(strobe_count - s0), 32'd4);
		s0 = strobe_count;
		run_access(1'b0, 16'h01F0, 3'd4, 32'h0);
		check_value("hdd0_strobes", 32'(strobe_count - s0), 32'd1);
		s0 = strobe_count;
		run_access(1'b0, 16'h0170, 3'd4, 32'h0);
		check_value("hdd1_strobes", 32'(strobe_count - s0), 32'd1);

		for (int i = 0; i < RANDOM_ACCESSES; i++) begin
			pick = int'($urandom % 26);
			run_access(1'($urandom % 2), rand_port[pick], 3'(1 << ($urandom % 3)), $urandom);
		end

		$display("*** PASSED ***");
		$finish;
	end

endmodule
